//--- rs_defines.svh
`ifndef RS_DEFINES_SVH
`define RS_DEFINES_SVH

// Data word width
`define RS_XLEN 32

// ROB index width
`define RS_ROB_IDX_W 5

`endif

//--- rs_pkg.sv
`include "rs_defines.svh"

package rs_pkg;

    typedef logic [`RS_XLEN-1:0]      word_t;
    typedef logic [`RS_ROB_IDX_W-1:0] rob_idx_t;
    typedef logic [1:0]               op_class_t;
    typedef logic [3:0]               func_op_t;

    localparam op_class_t CLASS_NONE = 2'd0;
    localparam op_class_t CLASS_ALU  = 2'd1;
    localparam op_class_t CLASS_MUL  = 2'd2;
    localparam op_class_t CLASS_BR   = 2'd3;

    // Integer ALU
    localparam func_op_t ADD   = 4'd0;
    localparam func_op_t SUB   = 4'd1;
    localparam func_op_t AND   = 4'd2;
    localparam func_op_t OR    = 4'd3;
    localparam func_op_t XOR   = 4'd4;
    localparam func_op_t SLL   = 4'd5;
    localparam func_op_t SRL   = 4'd6;
    localparam func_op_t SRA   = 4'd7;
    localparam func_op_t SLT   = 4'd8;
    localparam func_op_t SLTU  = 4'd9;

    // Multiplier
    localparam func_op_t MUL   = 4'd0;
    localparam func_op_t MULH  = 4'd1;
    localparam func_op_t MULHU = 4'd2;

    // Branch compare
    localparam func_op_t BEQ   = 4'd0;
    localparam func_op_t BNE   = 4'd1;
    localparam func_op_t BLT   = 4'd2;
    localparam func_op_t BGE   = 4'd3;
    localparam func_op_t BLTU  = 4'd4;
    localparam func_op_t BGEU  = 4'd5;

    typedef enum logic [1:0] {
        IDLE,
        WAITING,
        ISSUED,
        COMPLETE
    } station_status_t;

    typedef struct packed {
        logic      valid;
        op_class_t op_class;
        func_op_t  op;
        word_t     pc;
        word_t     imm;
        logic      use_imm;
        rob_idx_t  rd_rob_idx;
        rob_idx_t  rs1_rob_idx;
        logic      rs1_ready;
        word_t     rs1_data;
        rob_idx_t  rs2_rob_idx;
        logic      rs2_ready;
        word_t     rs2_data;
    } dispatch_t;

    typedef struct packed {
        op_class_t       op_class;
        func_op_t        op;
        word_t           pc;
        word_t           imm;
        logic            use_imm;
        rob_idx_t        rd_rob_idx;
        rob_idx_t        rs1_rob_idx;
        logic            rs1_ready;
        word_t           rs1_data;
        rob_idx_t        rs2_rob_idx;
        logic            rs2_ready;
        word_t           rs2_data;
        station_status_t status;
    } station_t;

    typedef struct packed {
        logic     valid;
        func_op_t op;
        word_t    a;
        word_t    b;
        word_t    pc;
        word_t    imm;
        rob_idx_t rob_idx;
    } issue_t;

    typedef struct packed {
        logic     alu_valid;
        rob_idx_t alu_rob_idx;
        word_t    alu_data;
        logic     mul_valid;
        rob_idx_t mul_rob_idx;
        word_t    mul_data;
        logic     br_valid;
        rob_idx_t br_rob_idx;
        logic     br_taken;
        word_t    br_target;
    } cdb_t;

endpackage

//--- reservation_station.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module reservation_station (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush,
    input  rs_pkg::dispatch_t  dispatch,
    input  rs_pkg::cdb_t       cdb,
    output rs_pkg::issue_t     alu_issue,
    output rs_pkg::issue_t     mul_issue,
    output rs_pkg::issue_t     br_issue,
    output logic               alu_available,
    output logic               mul_available,
    output logic               br_available
);

    // Slot 0 is ALU, 1 is multiply, 2 is branch
    rs_pkg::station_t stations [3];
    rs_pkg::station_t new_entry;
    rs_pkg::issue_t   issue_q [3];
    logic [2:0]       avail;
    logic [2:0]       disp_hit;
    logic [2:0]       done_hit;

    // Returns {ready, data} after looking at the ALU and multiply lanes
    function automatic logic [`RS_XLEN:0] snoop(
        input logic             ready,
        input rs_pkg::rob_idx_t tag,
        input rs_pkg::word_t    data,
        input rs_pkg::cdb_t     bus
    );
        logic [`RS_XLEN:0] res;
        res = {ready, data};
        if (!ready) begin
            if (bus.alu_valid && bus.alu_rob_idx == tag) begin
                res = {1'b1, bus.alu_data};
            end else if (bus.mul_valid && bus.mul_rob_idx == tag) begin
                res = {1'b1, bus.mul_data};
            end
        end
        return res;
    endfunction

    always_comb begin
        new_entry.op_class    = dispatch.op_class;
        new_entry.op          = dispatch.op;
        new_entry.pc          = dispatch.pc;
        new_entry.imm         = dispatch.imm;
        new_entry.use_imm     = dispatch.use_imm;
        new_entry.rd_rob_idx  = dispatch.rd_rob_idx;
        new_entry.rs1_rob_idx = dispatch.rs1_rob_idx;
        new_entry.rs2_rob_idx = dispatch.rs2_rob_idx;
        new_entry.status      = rs_pkg::WAITING;
        // Same-cycle bypass from the CDB
        {new_entry.rs1_ready, new_entry.rs1_data} =
            snoop(dispatch.rs1_ready, dispatch.rs1_rob_idx, dispatch.rs1_data, cdb);
        {new_entry.rs2_ready, new_entry.rs2_data} =
            snoop(dispatch.rs2_ready, dispatch.rs2_rob_idx, dispatch.rs2_data, cdb);
    end

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            disp_hit[i] = dispatch.valid && dispatch.op_class == rs_pkg::op_class_t'(i + 1);
            avail[i]    = stations[i].status == rs_pkg::IDLE ||
                          stations[i].status == rs_pkg::COMPLETE;
            done_hit[i] = (stations[i].status == rs_pkg::WAITING ||
                           stations[i].status == rs_pkg::ISSUED) &&
                          ((cdb.alu_valid && cdb.alu_rob_idx == stations[i].rd_rob_idx) ||
                           (cdb.mul_valid && cdb.mul_rob_idx == stations[i].rd_rob_idx) ||
                           (cdb.br_valid && cdb.br_rob_idx == stations[i].rd_rob_idx));

            issue_q[i].valid   = stations[i].status == rs_pkg::WAITING &&
                                 stations[i].rs1_ready &&
                                 (stations[i].use_imm || stations[i].rs2_ready);
            issue_q[i].op      = stations[i].op;
            issue_q[i].a       = stations[i].rs1_data;
            issue_q[i].b       = stations[i].use_imm ? stations[i].imm : stations[i].rs2_data;
            issue_q[i].pc      = stations[i].pc;
            issue_q[i].imm     = stations[i].imm;
            issue_q[i].rob_idx = stations[i].rd_rob_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 3; i++) begin
                stations[i].status <= rs_pkg::IDLE;
            end
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (flush) begin
                    stations[i].status <= rs_pkg::IDLE;
                end else if (disp_hit[i]) begin
                    stations[i] <= new_entry;
                end else begin
                    if (stations[i].status == rs_pkg::WAITING) begin
                        {stations[i].rs1_ready, stations[i].rs1_data} <= snoop(
                            stations[i].rs1_ready, stations[i].rs1_rob_idx,
                            stations[i].rs1_data, cdb);
                        {stations[i].rs2_ready, stations[i].rs2_data} <= snoop(
                            stations[i].rs2_ready, stations[i].rs2_rob_idx,
                            stations[i].rs2_data, cdb);
                    end
                    if (issue_q[i].valid) begin
                        stations[i].status <= rs_pkg::ISSUED;
                    end
                    // Completion wins over issue
                    if (done_hit[i]) begin
                        stations[i].status <= rs_pkg::COMPLETE;
                    end
                end
            end
        end
    end

    assign alu_issue     = issue_q[0];
    assign mul_issue     = issue_q[1];
    assign br_issue      = issue_q[2];
    assign alu_available = avail[0];
    assign mul_available = avail[1];
    assign br_available  = avail[2];

    for (genvar g = 0; g < 3; g++) begin : g_chk
        // Dispatcher must wait for the station to drain
        a_disp_avail: assert property (@(posedge clk) disable iff (!rst_n)
            disp_hit[g] |-> avail[g]);

        a_issue_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            issue_q[g].valid |=> !issue_q[g].valid);
    end

endmodule

//--- int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  rs_pkg::issue_t   issue,
    output logic             alu_valid,
    output rs_pkg::rob_idx_t alu_rob_idx,
    output rs_pkg::word_t    alu_data
);

    rs_pkg::word_t result;
    logic [4:0]    shamt;

    assign shamt = issue.b[4:0];

    always_comb begin
        case (issue.op)
            rs_pkg::ADD:  result = issue.a + issue.b;
            rs_pkg::SUB:  result = issue.a - issue.b;
            rs_pkg::AND:  result = issue.a & issue.b;
            rs_pkg::OR:   result = issue.a | issue.b;
            rs_pkg::XOR:  result = issue.a ^ issue.b;
            rs_pkg::SLL:  result = issue.a << shamt;
            rs_pkg::SRL:  result = issue.a >> shamt;
            rs_pkg::SRA:  result = rs_pkg::word_t'($signed(issue.a) >>> shamt);
            rs_pkg::SLT:  result = rs_pkg::word_t'($signed(issue.a) < $signed(issue.b));
            rs_pkg::SLTU: result = rs_pkg::word_t'(issue.a < issue.b);
            default:      result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue.valid && !flush;
        end
    end

    // Result and tag
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            alu_rob_idx <= issue.rob_idx;
            alu_data    <= result;
        end
    end

endmodule

//--- mult_unit.sv
`timescale 1ns/1ps
`include "rs_defines.svh"

module mult_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  rs_pkg::issue_t   issue,
    output logic             mul_valid,
    output rs_pkg::rob_idx_t mul_rob_idx,
    output rs_pkg::word_t    mul_data
);

    logic                          sign_a;
    logic                          sign_b;
    logic signed [2*`RS_XLEN-1:0]  a_ext;
    logic signed [2*`RS_XLEN-1:0]  b_ext;
    logic signed [2*`RS_XLEN-1:0]  product;

    logic                          s1_valid;
    rs_pkg::rob_idx_t              s1_rob_idx;
    logic                          s1_high;
    logic [2*`RS_XLEN-1:0]         s1_prod;

    // Only MULH treats the operands as signed
    assign sign_a  = issue.op == rs_pkg::MULH && issue.a[`RS_XLEN-1];
    assign sign_b  = issue.op == rs_pkg::MULH && issue.b[`RS_XLEN-1];
    assign a_ext   = {{`RS_XLEN{sign_a}}, issue.a};
    assign b_ext   = {{`RS_XLEN{sign_b}}, issue.b};
    assign product = a_ext * b_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            mul_valid <= 1'b0;
        end else begin
            s1_valid  <= issue.valid && !flush;
            mul_valid <= s1_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            s1_rob_idx <= issue.rob_idx;
            s1_high    <= issue.op != rs_pkg::MUL;
            s1_prod    <= product;
        end
        // Half select
        if (s1_valid) begin
            mul_rob_idx <= s1_rob_idx;
            mul_data    <= s1_high ? s1_prod[2*`RS_XLEN-1:`RS_XLEN] : s1_prod[`RS_XLEN-1:0];
        end
    end

endmodule

//--- branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,
    input  rs_pkg::issue_t   issue,
    output logic             br_valid,
    output rs_pkg::rob_idx_t br_rob_idx,
    output logic             br_taken,
    output rs_pkg::word_t    br_target
);

    logic taken;

    always_comb begin
        case (issue.op)
            rs_pkg::BEQ:  taken = issue.a == issue.b;
            rs_pkg::BNE:  taken = issue.a != issue.b;
            rs_pkg::BLT:  taken = $signed(issue.a) < $signed(issue.b);
            rs_pkg::BGE:  taken = $signed(issue.a) >= $signed(issue.b);
            rs_pkg::BLTU: taken = issue.a < issue.b;
            rs_pkg::BGEU: taken = issue.a >= issue.b;
            default:      taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            br_valid <= 1'b0;
        end else begin
            br_valid <= issue.valid && !flush;
        end
    end

    // Target is computed even when not taken
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            br_rob_idx <= issue.rob_idx;
            br_taken   <= taken;
            br_target  <= issue.pc + issue.imm;
        end
    end

endmodule

//--- issue_core.sv
`timescale 1ns/1ps

module issue_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              flush,
    input  rs_pkg::dispatch_t dispatch,
    output rs_pkg::cdb_t      cdb,
    output logic              alu_available,
    output logic              mul_available,
    output logic              br_available
);

    rs_pkg::issue_t   alu_issue;
    rs_pkg::issue_t   mul_issue;
    rs_pkg::issue_t   br_issue;

    logic             alu_valid;
    rs_pkg::rob_idx_t alu_rob_idx;
    rs_pkg::word_t    alu_data;
    logic             mul_valid;
    rs_pkg::rob_idx_t mul_rob_idx;
    rs_pkg::word_t    mul_data;
    logic             br_valid;
    rs_pkg::rob_idx_t br_rob_idx;
    logic             br_taken;
    rs_pkg::word_t    br_target;

    reservation_station u_rs (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .alu_issue     (alu_issue),
        .mul_issue     (mul_issue),
        .br_issue      (br_issue),
        .alu_available (alu_available),
        .mul_available (mul_available),
        .br_available  (br_available)
    );

    int_alu u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue       (alu_issue),
        .alu_valid   (alu_valid),
        .alu_rob_idx (alu_rob_idx),
        .alu_data    (alu_data)
    );

    mult_unit u_mul (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .issue       (mul_issue),
        .mul_valid   (mul_valid),
        .mul_rob_idx (mul_rob_idx),
        .mul_data    (mul_data)
    );

    branch_unit u_br (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .issue      (br_issue),
        .br_valid   (br_valid),
        .br_rob_idx (br_rob_idx),
        .br_taken   (br_taken),
        .br_target  (br_target)
    );

    // One lane per unit
    assign cdb = '{
        alu_valid:   alu_valid,
        alu_rob_idx: alu_rob_idx,
        alu_data:    alu_data,
        mul_valid:   mul_valid,
        mul_rob_idx: mul_rob_idx,
        mul_data:    mul_data,
        br_valid:    br_valid,
        br_rob_idx:  br_rob_idx,
        br_taken:    br_taken,
        br_target:   br_target
    };

endmodule

//--- tb_issue_core.sv
`timescale 1ns/1ps

module tb_issue_core;

    logic              clk;
    logic              rst_n;
    logic              flush;
    rs_pkg::dispatch_t dispatch;
    rs_pkg::cdb_t      cdb;
    logic              alu_available;
    logic              mul_available;
    logic              br_available;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    issue_core u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .alu_available (alu_available),
        .mul_available (mul_available),
        .br_available  (br_available)
    );

    always #20 clk = ~clk;

    a_flush_frees: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> alu_available && mul_available && br_available)
        else begin
            $display("Stations still busy one cycle after flush at %0t", $time);
            errors++;
        end

    // Units drop whatever they hold at the flush edge
    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !(cdb.alu_valid || cdb.mul_valid || cdb.br_valid))
        else begin
            $display("CDB lane valid right after flush at %0t", $time);
            errors++;
        end

    function automatic rs_pkg::word_t alu_ref(input rs_pkg::func_op_t op,
                                              input rs_pkg::word_t a, input rs_pkg::word_t b);
        case (op)
            rs_pkg::ADD:  return a + b;
            rs_pkg::SUB:  return a - b;
            rs_pkg::AND:  return a & b;
            rs_pkg::OR:   return a | b;
            rs_pkg::XOR:  return a ^ b;
            rs_pkg::SLL:  return a << b[4:0];
            rs_pkg::SRL:  return a >> b[4:0];
            rs_pkg::SRA:  return $signed(a) >>> b[4:0];
            rs_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:      return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic rs_pkg::word_t mul_ref(input rs_pkg::func_op_t op,
                                              input rs_pkg::word_t a, input rs_pkg::word_t b);
        longint      sp;
        logic [63:0] up;
        sp = longint'($signed(a)) * longint'($signed(b));
        up = {32'b0, a} * {32'b0, b};
        case (op)
            rs_pkg::MUL:  return sp[31:0];
            rs_pkg::MULH: return sp[63:32];
            default:      return up[63:32];
        endcase
    endfunction

    function automatic logic br_ref(input rs_pkg::func_op_t op,
                                    input rs_pkg::word_t a, input rs_pkg::word_t b);
        case (op)
            rs_pkg::BEQ:  return a == b;
            rs_pkg::BNE:  return a != b;
            rs_pkg::BLT:  return $signed(a) < $signed(b);
            rs_pkg::BGE:  return !($signed(a) < $signed(b));
            rs_pkg::BLTU: return a < b;
            default:      return !(a < b);
        endcase
    endfunction

    function automatic rs_pkg::dispatch_t ready_op(input rs_pkg::op_class_t cls,
                                                   input rs_pkg::func_op_t op,
                                                   input rs_pkg::word_t a, input rs_pkg::word_t b,
                                                   input rs_pkg::rob_idx_t tag);
        rs_pkg::dispatch_t d;
        d            = '0;
        d.valid      = 1'b1;
        d.op_class   = cls;
        d.op         = op;
        d.rd_rob_idx = tag;
        d.rs1_ready  = 1'b1;
        d.rs1_data   = a;
        d.rs2_ready  = 1'b1;
        d.rs2_data   = b;
        return d;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
            else begin
                $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
                errors++;
            end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
            else begin
                $display("%s at %0t", what, $time);
                errors++;
            end
    endtask

    // Returns just after the dispatch edge
    task automatic send(input rs_pkg::dispatch_t d);
        @(posedge clk);
        #2;
        dispatch = d;
        @(posedge clk);
        #2;
        dispatch.valid = 1'b0;
    endtask

    task automatic wait_lane(input int lane, output int cycles);
        logic hit;
        logic avail;
        cycles = 0;
        hit    = 1'b0;
        while (!hit && cycles < 20) begin
            @(negedge clk);
            cycles++;
            hit   = lane == 0 ? cdb.alu_valid : lane == 1 ? cdb.mul_valid : cdb.br_valid;
            avail = lane == 0 ? alu_available : lane == 1 ? mul_available : br_available;
            check_true(!avail, "Station available before its result was broadcast");
        end
        if (!hit) begin
            $display("Timeout waiting for CDB lane %0d at %0t", lane, $time);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - mark);
        end
    endtask

    initial begin
        rs_pkg::dispatch_t d;
        rs_pkg::word_t     a;
        rs_pkg::word_t     b;
        rs_pkg::word_t     m;
        rs_pkg::rob_idx_t  tag;
        int                n;
        int                mark;

        void'($urandom(32'h0f7417e2));
        clk      = 1'b0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        dispatch = '0;
        tag      = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        mark = errors;
        @(negedge clk);
        check_true(alu_available && mul_available && br_available, "Station busy after reset");
        check_true(!(cdb.alu_valid || cdb.mul_valid || cdb.br_valid), "CDB valid after reset");
        end_test("reset", mark);

        mark = errors;
        for (int k = 0; k < 11; k++) begin
            a   = $urandom;
            b   = $urandom;
            tag = tag + 5'd1;
            d   = ready_op(rs_pkg::CLASS_ALU, rs_pkg::func_op_t'(k % 10), a, b, tag);
            // Last pass uses the immediate and leaves rs2 not ready
            if (k == 10) begin
                d.use_imm   = 1'b1;
                d.imm       = $urandom & 32'h0000_0fff;
                d.rs2_ready = 1'b0;
                b           = d.imm;
            end
            send(d);
            wait_lane(0, n);
            check_value("alu latency", n, 2);
            check_value("cdb.alu_rob_idx", cdb.alu_rob_idx, tag);
            check_value("cdb.alu_data", cdb.alu_data, alu_ref(d.op, a, b));
            @(negedge clk);
            check_true(alu_available, "alu_available low after completion");
        end
        end_test("alu ops", mark);

        mark = errors;
        for (int k = 0; k < 6; k++) begin
            a   = (k < 3) ? $urandom : ($urandom | 32'h8000_0000);
            b   = $urandom;
            tag = tag + 5'd1;
            d   = ready_op(rs_pkg::CLASS_MUL, rs_pkg::func_op_t'(k % 3), a, b, tag);
            send(d);
            wait_lane(1, n);
            check_value("mul latency", n, 3);
            check_value("cdb.mul_rob_idx", cdb.mul_rob_idx, tag);
            check_value("cdb.mul_data", cdb.mul_data, mul_ref(d.op, a, b));
        end
        end_test("multiply ops", mark);

        mark = errors;
        a   = $urandom;
        b   = $urandom;
        m   = mul_ref(rs_pkg::MUL, a, b);
        tag = tag + 5'd1;
        send(ready_op(rs_pkg::CLASS_MUL, rs_pkg::MUL, a, b, tag));
        d             = ready_op(rs_pkg::CLASS_ALU, rs_pkg::SUB, 32'h0, $urandom, tag + 5'd1);
        d.rs1_ready   = 1'b0;
        d.rs1_rob_idx = tag;
        send(d);
        wait_lane(1, n);
        check_value("cdb.mul_data", cdb.mul_data, m);
        wait_lane(0, n);
        check_value("wakeup alu latency", n, 2);
        check_value("cdb.alu_data", cdb.alu_data, alu_ref(rs_pkg::SUB, m, d.rs2_data));
        tag = tag + 5'd2;
        m   = mul_ref(rs_pkg::MULHU, a, b);
        send(ready_op(rs_pkg::CLASS_MUL, rs_pkg::MULHU, a, b, tag));
        @(posedge clk);
        #2;
        // This dispatch lands in the broadcast cycle
        d             = ready_op(rs_pkg::CLASS_ALU, rs_pkg::XOR, 32'h0, $urandom, tag + 5'd1);
        d.rs1_ready   = 1'b0;
        d.rs1_rob_idx = tag;
        send(d);
        wait_lane(0, n);
        check_value("bypass alu latency", n, 2);
        check_value("cdb.alu_data", cdb.alu_data, alu_ref(rs_pkg::XOR, m, d.rs2_data));
        tag = tag + 5'd1;
        end_test("wakeup", mark);

        mark = errors;
        for (int k = 0; k < 18; k++) begin
            a = $urandom;
            b = a;
            if (k % 3 == 1) begin
                // Both positive with a just below b
                a = a & 32'h3fff_ffff;
                b = a + 32'd1;
            end else if (k % 3 == 2) begin
                // Sign bits differ so signed and unsigned order disagree
                b = a | 32'h8000_0000;
                a = b ^ 32'h8000_0001;
            end
            tag     = tag + 5'd1;
            d       = ready_op(rs_pkg::CLASS_BR, rs_pkg::func_op_t'(k / 3), a, b, tag);
            d.pc    = $urandom & 32'hffff_fffc;
            d.imm   = $urandom & 32'h0000_1ffe;
            send(d);
            wait_lane(2, n);
            check_value("branch latency", n, 2);
            check_value("cdb.br_rob_idx", cdb.br_rob_idx, tag);
            check_value("cdb.br_taken", cdb.br_taken, br_ref(d.op, a, b));
            check_value("cdb.br_target", cdb.br_target, d.pc + d.imm);
        end
        end_test("branch ops", mark);

        mark = errors;
        d             = ready_op(rs_pkg::CLASS_ALU, rs_pkg::ADD, 32'h0, $urandom, 5'd30);
        d.rs1_ready   = 1'b0;
        d.rs1_rob_idx = 5'd29;
        send(d);
        @(negedge clk);
        check_true(!alu_available, "ALU station free while its operand is pending");
        @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        @(negedge clk);
        check_true(alu_available, "alu_available low after flush");
        send(ready_op(rs_pkg::CLASS_MUL, rs_pkg::MUL, $urandom, $urandom, 5'd29));
        wait_lane(1, n);
        repeat (4) begin
            @(negedge clk);
            check_true(!cdb.alu_valid, "Flushed ALU op produced a result");
        end
        send(ready_op(rs_pkg::CLASS_MUL, rs_pkg::MULH, $urandom, $urandom, 5'd28));
        @(posedge clk);
        #2;
        flush = 1'b1;
        @(posedge clk);
        #2;
        flush = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_true(!cdb.mul_valid, "Flushed multiply reached the CDB");
        end
        check_true(mul_available, "mul_available low after flush");
        end_test("flush", mark);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
rs_pkg.sv
reservation_station.sv
int_alu.sv
mult_unit.sv
branch_unit.sv
issue_core.sv
tb_issue_core.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_issue_core
FILELIST = verilog.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST)) rs_defines.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
